/* include/bgpu_macros.svh */
// ####################
// Sizing of the GPU front end
// Included by the package, the fetcher, the memory and the top level
// ####################
`ifndef BGPU_MACROS_SVH
`define BGPU_MACROS_SVH

// Warps per compute unit
`define BGPU_NUM_WARPS 8

// Threads per warp, one mask bit each
`define BGPU_WARP_WIDTH 32

// Program counter width in words
`define BGPU_PC_WIDTH 16

// Instruction memory depth in 32 bit words
`define BGPU_IMEM_DEPTH 256

`endif

/* src/bgpu_pkg.sv */
// ####################
// Shared types of the GPU front end
// Referenced by scoped name from the modules and the interface
// ####################
`include "bgpu_macros.svh"

package bgpu_pkg;

    // Word address of an instruction
    typedef logic [`BGPU_PC_WIDTH-1:0] pc_t;

    // Warp index
    typedef logic [$clog2(`BGPU_NUM_WARPS)-1:0] wid_t;

    // One enable bit per thread
    typedef logic [`BGPU_WARP_WIDTH-1:0] act_mask_t;

    // Raw instruction word as stored in memory
    typedef logic [31:0] enc_inst_t;

    // Register index for dst and operands
    typedef logic [7:0] reg_idx_t;

    // Execution unit in the upper opcode nibble
    // 4'hF with subtype 4'hF forms the stop opcode 8'hFF
    typedef enum logic [3:0] {
        EU_IU  = 4'h0,
        EU_LSU = 4'h1,
        EU_BRU = 4'h2
    } eu_e;

    // Integer unit operations
    // Register forms first, then the immediate forms
    typedef enum logic [3:0] {
        IU_ADD  = 4'h0,
        IU_SUB  = 4'h1,
        IU_AND  = 4'h2,
        IU_OR   = 4'h3,
        IU_XOR  = 4'h4,
        IU_SLL  = 4'h5,
        IU_ADDI = 4'h6,
        IU_SUBI = 4'h7,
        IU_SLLI = 4'h8
    } iu_sub_e;

    // Branch unit operations
    // BR is passed on as a plain instruction
    typedef enum logic [3:0] {
        BRU_JMP = 4'h0,
        BRU_BR  = 4'h1
    } bru_sub_e;

    // Opcode byte, unit in the upper nibble
    typedef struct packed {
        eu_e        eu;
        logic [3:0] subtype;
    } inst_t;

    // Per warp fetch state
    typedef enum logic [1:0] {
        IDLE,
        READY,
        WAIT
    } warp_state_e;

endpackage

/* src/decode_if.sv */
// ####################
// Fetched instruction from memory stage to decoder
// Memory drives source, decoder drives sink
// ####################
`timescale 1ns/1ps

interface decode_if;

    // Handshake, transfer when both are high
    logic                ic_valid;
    logic                ic_ready;

    // Payload, stable while valid and not ready
    bgpu_pkg::pc_t       pc;
    bgpu_pkg::act_mask_t act_mask;
    bgpu_pkg::wid_t      warp_id;
    bgpu_pkg::enc_inst_t inst;

    // Instruction memory side
    modport source (
        output ic_valid, pc, act_mask, warp_id, inst,
        input  ic_ready
    );

    // Decoder side
    modport sink (
        input  ic_valid, pc, act_mask, warp_id, inst,
        output ic_ready
    );

endinterface

/* src/fetcher.sv */
// ####################
// Per warp PC table with round robin fetch
// Starts warps from outside and follows decode results
// ####################
`timescale 1ns/1ps
`include "bgpu_macros.svh"

module fetcher (
    input  logic                       clk_i,
    input  logic                       reset_i,
    // Warp launch
    input  logic                       start_i,
    input  bgpu_pkg::wid_t             start_warp_id_i,
    input  bgpu_pkg::pc_t              start_pc_i,
    input  bgpu_pkg::act_mask_t        start_mask_i,
    // Instruction memory request
    input  logic                       mem_busy_i,
    output logic                       fetch_valid_o,
    output bgpu_pkg::pc_t              fetch_pc_o,
    output bgpu_pkg::wid_t             fetch_warp_id_o,
    output bgpu_pkg::act_mask_t        fetch_mask_o,
    // Decode feedback, valid with dec_decoded_i
    input  logic                       dec_decoded_i,
    input  logic                       dec_stop_warp_i,
    input  bgpu_pkg::wid_t             dec_decoded_warp_id_i,
    input  bgpu_pkg::pc_t              dec_next_pc_i,
    // One bit per warp that is not IDLE
    output logic [`BGPU_NUM_WARPS-1:0] warps_active_o
);
    bgpu_pkg::warp_state_e state_q [`BGPU_NUM_WARPS];
    bgpu_pkg::pc_t         pc_q    [`BGPU_NUM_WARPS];
    bgpu_pkg::act_mask_t   mask_q  [`BGPU_NUM_WARPS];

    // Last warp served, search starts one above
    bgpu_pkg::wid_t rr_ptr_q;
    logic           pick_valid;
    bgpu_pkg::wid_t pick_wid;

    // First READY warp after the last one served
    always_comb begin : rr_pick
        bgpu_pkg::wid_t idx;
        pick_valid = 1'b0;
        pick_wid   = rr_ptr_q;
        for (int i = 1; i <= `BGPU_NUM_WARPS; i++) begin
            // Wraps around the warp count
            idx = bgpu_pkg::wid_t'(rr_ptr_q + i);
            if (!pick_valid && state_q[idx] == bgpu_pkg::READY) begin
                pick_valid = 1'b1;
                pick_wid   = idx;
            end
        end
    end

    // No request while memory still holds a word
    assign fetch_valid_o   = pick_valid && !mem_busy_i;
    assign fetch_pc_o      = pc_q[pick_wid];
    assign fetch_warp_id_o = pick_wid;
    assign fetch_mask_o    = mask_q[pick_wid];

    always_ff @(posedge clk_i) begin : state_update
        if (reset_i) begin
            // Warp 0 is served first after reset
            rr_ptr_q <= '1;
            for (int w = 0; w < `BGPU_NUM_WARPS; w++)
                state_q[w] <= bgpu_pkg::IDLE;
        end else begin
            if (fetch_valid_o)
                rr_ptr_q <= pick_wid;
            for (int w = 0; w < `BGPU_NUM_WARPS; w++) begin
                if (start_i && start_warp_id_i == bgpu_pkg::wid_t'(w))
                    state_q[w] <= bgpu_pkg::READY;
                else if (fetch_valid_o && pick_wid == bgpu_pkg::wid_t'(w))
                    state_q[w] <= bgpu_pkg::WAIT;
                // Decode returns the warp, or retires it on stop
                else if (dec_decoded_i && dec_decoded_warp_id_i == bgpu_pkg::wid_t'(w))
                    state_q[w] <= dec_stop_warp_i ? bgpu_pkg::IDLE : bgpu_pkg::READY;
            end
        end
    end

    // PC follows start and decode, mask is fixed per launch
    always_ff @(posedge clk_i) begin : pc_update
        for (int w = 0; w < `BGPU_NUM_WARPS; w++) begin
            if (start_i && start_warp_id_i == bgpu_pkg::wid_t'(w)) begin
                pc_q[w]   <= start_pc_i;
                mask_q[w] <= start_mask_i;
            end else if (dec_decoded_i && dec_decoded_warp_id_i == bgpu_pkg::wid_t'(w)) begin
                pc_q[w] <= dec_next_pc_i;
            end
        end
    end

    always_comb begin : active_bits
        for (int w = 0; w < `BGPU_NUM_WARPS; w++)
            warps_active_o[w] = state_q[w] != bgpu_pkg::IDLE;
    end

    // Launch only into a free warp slot
    a_start_idle : assert property (@(posedge clk_i) disable iff (reset_i)
        start_i |-> state_q[start_warp_id_i] == bgpu_pkg::IDLE)
        else $error("start of warp %0d which is still running", start_warp_id_i);

    // Decoder only answers for warps with a fetch in flight
    a_decode_wait : assert property (@(posedge clk_i) disable iff (reset_i)
        dec_decoded_i |-> state_q[dec_decoded_warp_id_i] == bgpu_pkg::WAIT)
        else $error("decode result for warp %0d not in WAIT", dec_decoded_warp_id_i);

endmodule

/* src/inst_mem.sv */
// ####################
// Instruction memory with external load port
// Read data registered and held until the decoder takes it
// ####################
`timescale 1ns/1ps
`include "bgpu_macros.svh"

module inst_mem (
    input  logic                clk_i,
    input  logic                reset_i,
    // Program load
    input  logic                we_i,
    input  bgpu_pkg::pc_t       waddr_i,
    input  bgpu_pkg::enc_inst_t wdata_i,
    // Fetch request
    input  logic                req_i,
    input  bgpu_pkg::pc_t       req_pc_i,
    input  bgpu_pkg::wid_t      req_warp_id_i,
    input  bgpu_pkg::act_mask_t req_mask_i,
    output logic                busy_o,
    // To decoder
    decode_if.source            ic
);
    localparam int unsigned AddrWidth = $clog2(`BGPU_IMEM_DEPTH);

    bgpu_pkg::enc_inst_t mem_q [`BGPU_IMEM_DEPTH];

    // Output stage
    logic                valid_q;
    bgpu_pkg::enc_inst_t inst_q;
    bgpu_pkg::pc_t       pc_q;
    bgpu_pkg::wid_t      wid_q;
    bgpu_pkg::act_mask_t mask_q;

    // Upper PC bits beyond the depth are ignored
    always_ff @(posedge clk_i) begin : mem_write
        if (we_i)
            mem_q[waddr_i[AddrWidth-1:0]] <= wdata_i;
    end

    // Valid until accepted, a new request in the same cycle refills it
    always_ff @(posedge clk_i) begin : out_valid
        if (reset_i)
            valid_q <= 1'b0;
        else if (req_i)
            valid_q <= 1'b1;
        else if (ic.ic_ready)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk_i) begin : out_data
        if (req_i) begin
            inst_q <= mem_q[req_pc_i[AddrWidth-1:0]];
            pc_q   <= req_pc_i;
            wid_q  <= req_warp_id_i;
            mask_q <= req_mask_i;
        end
    end

    assign ic.ic_valid = valid_q;
    assign ic.inst     = inst_q;
    assign ic.pc       = pc_q;
    assign ic.warp_id  = wid_q;
    assign ic.act_mask = mask_q;

    // Holding a word the decoder has not taken
    assign busy_o = valid_q && !ic.ic_ready;

    // Fetcher must respect busy, otherwise the held word is lost
    a_no_req_busy : assert property (@(posedge clk_i) disable iff (reset_i)
        req_i |-> !busy_o)
        else $error("fetch request while memory output is stalled");

endmodule

/* src/decoder.sv */
// ####################
// Instruction decoder, purely combinational
// Resolves jump and stop for the fetcher, passes the rest on
// ####################
`timescale 1ns/1ps

module decoder (
    // From instruction memory
    decode_if.sink                         ic,
    // To dispatch buffer
    input  logic                           disp_ready_i,
    output logic                           dec_valid_o,
    output bgpu_pkg::inst_t                dec_inst_o,
    output bgpu_pkg::reg_idx_t             dec_dst_o,
    output bgpu_pkg::reg_idx_t [1:0]       dec_operands_o,
    output logic               [1:0]       dec_operands_required_o,
    output bgpu_pkg::pc_t                  dec_pc_o,
    output bgpu_pkg::wid_t                 dec_warp_id_o,
    output bgpu_pkg::act_mask_t            dec_act_mask_o,
    // To fetcher, sampled with dec_decoded_o
    output logic                           dec_decoded_o,
    output logic                           dec_stop_warp_o,
    output bgpu_pkg::wid_t                 dec_decoded_warp_id_o,
    output bgpu_pkg::pc_t                  dec_decoded_next_pc_o
);
    logic is_control;

    // Field split of the 32 bit word
    assign dec_inst_o        = bgpu_pkg::inst_t'(ic.inst[31:24]);
    assign dec_dst_o         = ic.inst[23:16];
    assign dec_operands_o[0] = ic.inst[15:8];
    assign dec_operands_o[1] = ic.inst[7:0];
    assign dec_pc_o          = ic.pc;
    assign dec_warp_id_o     = ic.warp_id;
    assign dec_act_mask_o    = ic.act_mask;

    // Opcode 8'hFF
    assign dec_stop_warp_o = ic.inst[31:24] == 8'hFF;

    // Control words are consumed here, so they never wait on the buffer
    assign ic.ic_ready   = disp_ready_i || is_control;
    assign dec_valid_o   = ic.ic_valid && !is_control;

    // Either a control word or a handshake into the buffer
    assign dec_decoded_o         = ic.ic_valid && ic.ic_ready;
    assign dec_decoded_warp_id_o = ic.warp_id;

    always_comb begin : decode
        // Sequential by default
        dec_decoded_next_pc_o   = ic.pc + 1'b1;
        dec_operands_required_o = 2'b00;
        is_control              = dec_stop_warp_o;

        case (dec_inst_o.eu)
            bgpu_pkg::EU_IU: begin
                // Register forms read both sources
                if (dec_inst_o.subtype inside {bgpu_pkg::IU_ADD, bgpu_pkg::IU_SUB,
                        bgpu_pkg::IU_AND, bgpu_pkg::IU_OR, bgpu_pkg::IU_XOR,
                        bgpu_pkg::IU_SLL})
                    dec_operands_required_o = 2'b11;
                // Operand 0 holds the immediate
                else if (dec_inst_o.subtype inside {bgpu_pkg::IU_ADDI,
                        bgpu_pkg::IU_SUBI, bgpu_pkg::IU_SLLI})
                    dec_operands_required_o = 2'b10;
            end
            // Address and store data
            bgpu_pkg::EU_LSU: begin
                dec_operands_required_o = 2'b11;
            end
            bgpu_pkg::EU_BRU: begin
                // Both operand bytes form a signed word offset
                // Conditional branches fall through as normal words
                if (dec_inst_o.subtype == bgpu_pkg::BRU_JMP) begin
                    dec_decoded_next_pc_o = ic.pc
                        + bgpu_pkg::pc_t'($signed(ic.inst[15:0]));
                    is_control            = 1'b1;
                end
            end
            default: begin
                // Unknown units issue without register operands
                dec_operands_required_o = 2'b00;
            end
        endcase
    end

endmodule

/* src/dispatch_buffer.sv */
// ####################
// One entry register slice between decoder and issue
// Accepts while empty or being drained in the same cycle
// ####################
`timescale 1ns/1ps

module dispatch_buffer (
    input  logic                     clk_i,
    input  logic                     reset_i,
    // From decoder
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  bgpu_pkg::inst_t          in_inst_i,
    input  bgpu_pkg::reg_idx_t       in_dst_i,
    input  bgpu_pkg::reg_idx_t [1:0] in_operands_i,
    input  logic               [1:0] in_operands_required_i,
    input  bgpu_pkg::pc_t            in_pc_i,
    input  bgpu_pkg::wid_t           in_warp_id_i,
    input  bgpu_pkg::act_mask_t      in_act_mask_i,
    // To issue
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output bgpu_pkg::inst_t          out_inst_o,
    output bgpu_pkg::reg_idx_t       out_dst_o,
    output bgpu_pkg::reg_idx_t [1:0] out_operands_o,
    output logic               [1:0] out_operands_required_o,
    output bgpu_pkg::pc_t            out_pc_o,
    output bgpu_pkg::wid_t           out_warp_id_o,
    output bgpu_pkg::act_mask_t      out_act_mask_o
);
    logic valid_q;

    // Free now, or free at this edge
    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;

    always_ff @(posedge clk_i) begin : slot_valid
        if (reset_i)
            valid_q <= 1'b0;
        else if (in_ready_o)
            valid_q <= in_valid_i;
    end

    // Payload loads on an accepted transfer only
    always_ff @(posedge clk_i) begin : slot_data
        if (in_valid_i && in_ready_o) begin
            out_inst_o              <= in_inst_i;
            out_dst_o               <= in_dst_i;
            out_operands_o          <= in_operands_i;
            out_operands_required_o <= in_operands_required_i;
            out_pc_o                <= in_pc_i;
            out_warp_id_o           <= in_warp_id_i;
            out_act_mask_o          <= in_act_mask_i;
        end
    end

    // Stalled record stays in place until taken
    a_stall_stable : assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_inst_o)
            && $stable(out_dst_o) && $stable(out_operands_o)
            && $stable(out_operands_required_o)
            && $stable(out_pc_o) && $stable(out_warp_id_o)
            && $stable(out_act_mask_o))
        else $error("issue record changed under back-pressure");

endmodule

/* src/bgpu_frontend.sv */
// ####################
// GPU compute unit front end, fetch to issue
// Load the memory, start warps, drain issue with valid/ready
// ####################
`timescale 1ns/1ps
`include "bgpu_macros.svh"

module bgpu_frontend (
    input  logic                       clk_i,
    input  logic                       reset_i,
    // Warp launch
    input  logic                       start_i,
    input  bgpu_pkg::wid_t             start_warp_id_i,
    input  bgpu_pkg::pc_t              start_pc_i,
    input  bgpu_pkg::act_mask_t        start_mask_i,
    // Program load
    input  logic                       imem_we_i,
    input  bgpu_pkg::pc_t              imem_addr_i,
    input  bgpu_pkg::enc_inst_t        imem_wdata_i,
    // Issue
    output logic                       issue_valid_o,
    input  logic                       issue_ready_i,
    output bgpu_pkg::inst_t            issue_inst_o,
    output bgpu_pkg::reg_idx_t         issue_dst_o,
    output bgpu_pkg::reg_idx_t [1:0]   issue_operands_o,
    output logic               [1:0]   issue_operands_required_o,
    output bgpu_pkg::pc_t              issue_pc_o,
    output bgpu_pkg::wid_t             issue_warp_id_o,
    output bgpu_pkg::act_mask_t        issue_act_mask_o,
    // Status
    output logic [`BGPU_NUM_WARPS-1:0] warps_active_o
);
    // Fetcher to memory
    logic                fetch_valid;
    bgpu_pkg::pc_t       fetch_pc;
    bgpu_pkg::wid_t      fetch_warp_id;
    bgpu_pkg::act_mask_t fetch_mask;
    logic                mem_busy;

    // Decoder feedback to fetcher
    logic                dec_decoded;
    logic                dec_stop_warp;
    bgpu_pkg::wid_t      dec_decoded_warp_id;
    bgpu_pkg::pc_t       dec_decoded_next_pc;

    // Decoder to buffer
    logic                     dec_valid;
    logic                     disp_ready;
    bgpu_pkg::inst_t          dec_inst;
    bgpu_pkg::reg_idx_t       dec_dst;
    bgpu_pkg::reg_idx_t [1:0] dec_operands;
    logic               [1:0] dec_operands_required;
    bgpu_pkg::pc_t            dec_pc;
    bgpu_pkg::wid_t           dec_warp_id;
    bgpu_pkg::act_mask_t      dec_act_mask;

    decode_if i_decode_if ();

    fetcher i_fetcher (
        .clk_i, .reset_i,
        .start_i, .start_warp_id_i, .start_pc_i, .start_mask_i,
        .mem_busy_i            (mem_busy),
        .fetch_valid_o         (fetch_valid),
        .fetch_pc_o            (fetch_pc),
        .fetch_warp_id_o       (fetch_warp_id),
        .fetch_mask_o          (fetch_mask),
        .dec_decoded_i         (dec_decoded),
        .dec_stop_warp_i       (dec_stop_warp),
        .dec_decoded_warp_id_i (dec_decoded_warp_id),
        .dec_next_pc_i         (dec_decoded_next_pc),
        .warps_active_o
    );

    inst_mem i_inst_mem (
        .clk_i, .reset_i,
        .we_i          (imem_we_i),
        .waddr_i       (imem_addr_i),
        .wdata_i       (imem_wdata_i),
        .req_i         (fetch_valid),
        .req_pc_i      (fetch_pc),
        .req_warp_id_i (fetch_warp_id),
        .req_mask_i    (fetch_mask),
        .busy_o        (mem_busy),
        .ic            (i_decode_if)
    );

    decoder i_decoder (
        .ic                      (i_decode_if),
        .disp_ready_i            (disp_ready),
        .dec_valid_o             (dec_valid),
        .dec_inst_o              (dec_inst),
        .dec_dst_o               (dec_dst),
        .dec_operands_o          (dec_operands),
        .dec_operands_required_o (dec_operands_required),
        .dec_pc_o                (dec_pc),
        .dec_warp_id_o           (dec_warp_id),
        .dec_act_mask_o          (dec_act_mask),
        .dec_decoded_o           (dec_decoded),
        .dec_stop_warp_o         (dec_stop_warp),
        .dec_decoded_warp_id_o   (dec_decoded_warp_id),
        .dec_decoded_next_pc_o   (dec_decoded_next_pc)
    );

    dispatch_buffer i_dispatch_buffer (
        .clk_i, .reset_i,
        .in_valid_i              (dec_valid),
        .in_ready_o              (disp_ready),
        .in_inst_i               (dec_inst),
        .in_dst_i                (dec_dst),
        .in_operands_i           (dec_operands),
        .in_operands_required_i  (dec_operands_required),
        .in_pc_i                 (dec_pc),
        .in_warp_id_i            (dec_warp_id),
        .in_act_mask_i           (dec_act_mask),
        .out_valid_o             (issue_valid_o),
        .out_ready_i             (issue_ready_i),
        .out_inst_o              (issue_inst_o),
        .out_dst_o               (issue_dst_o),
        .out_operands_o          (issue_operands_o),
        .out_operands_required_o (issue_operands_required_o),
        .out_pc_o                (issue_pc_o),
        .out_warp_id_o           (issue_warp_id_o),
        .out_act_mask_o          (issue_act_mask_o)
    );

endmodule

/* tb/tb_bgpu_frontend.sv */
// ####################
// Testbench for the GPU front end
// Loads a program, starts warps, checks every issued record
// ####################
`timescale 1ns/1ps
`include "bgpu_macros.svh"

module tb_bgpu_frontend;

    localparam int NumProg   = 19;
    localparam int NumStarts = 6;
    localparam int AddrBits  = $clog2(`BGPU_IMEM_DEPTH);

    // One expected issue record
    typedef struct packed {
        bgpu_pkg::wid_t      wid;
        logic [7:0]          inst;
        logic [7:0]          dst;
        logic [7:0]          op0;
        logic [7:0]          op1;
        logic [1:0]          req;
        bgpu_pkg::pc_t       pc;
        bgpu_pkg::act_mask_t mask;
    } rec_t;

    logic                       clk_i = 1'b0;
    logic                       reset_i;
    logic                       start_i;
    bgpu_pkg::wid_t             start_warp_id_i;
    bgpu_pkg::pc_t              start_pc_i;
    bgpu_pkg::act_mask_t        start_mask_i;
    logic                       imem_we_i;
    bgpu_pkg::pc_t              imem_addr_i;
    bgpu_pkg::enc_inst_t        imem_wdata_i;
    logic                       issue_valid_o;
    logic                       issue_ready_i;
    bgpu_pkg::inst_t            issue_inst_o;
    bgpu_pkg::reg_idx_t         issue_dst_o;
    bgpu_pkg::reg_idx_t [1:0]   issue_operands_o;
    logic               [1:0]   issue_operands_required_o;
    bgpu_pkg::pc_t              issue_pc_o;
    bgpu_pkg::wid_t             issue_warp_id_o;
    bgpu_pkg::act_mask_t        issue_act_mask_o;
    logic [`BGPU_NUM_WARPS-1:0] warps_active_o;

    // Address and word per program entry
    logic [47:0]         prog_tbl  [NumProg];
    // Warp id, start PC and mask per launch
    logic [50:0]         start_tbl [NumStarts];
    bgpu_pkg::enc_inst_t prog_mem  [`BGPU_IMEM_DEPTH];
    rec_t                exp_q     [$];
    int                  cycles;
    int                  limit;
    logic                running;

    bgpu_frontend i_dut (
        .clk_i, .reset_i,
        .start_i, .start_warp_id_i, .start_pc_i, .start_mask_i,
        .imem_we_i, .imem_addr_i, .imem_wdata_i,
        .issue_valid_o, .issue_ready_i, .issue_inst_o, .issue_dst_o,
        .issue_operands_o, .issue_operands_required_o, .issue_pc_o,
        .issue_warp_id_o, .issue_act_mask_o,
        .warps_active_o
    );

    always #10 clk_i = ~clk_i;

    task automatic stop_failed();
        $display("Done: errors found");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
            stop_failed();
        end
    endtask

    // Register forms and LSU read both, immediates only operand 1
    function automatic logic [1:0] operand_flags(input logic [7:0] opcode);
        logic [1:0] flags;
        flags = 2'b00;
        if (opcode[7:4] == 4'h0 && opcode[3:0] <= 4'h5)
            flags = 2'b11;
        else if (opcode[7:4] == 4'h0 && opcode[3:0] <= 4'h8)
            flags = 2'b10;
        else if (opcode[7:4] == 4'h1)
            flags = 2'b11;
        return flags;
    endfunction

    // Walk one launch until stop and queue what it must issue
    task automatic expect_start(input int n);
        bgpu_pkg::wid_t      wid;
        bgpu_pkg::pc_t       pc;
        bgpu_pkg::act_mask_t mask;
        bgpu_pkg::enc_inst_t word;
        rec_t                rec;
        int                  steps;
        {wid, pc, mask} = start_tbl[n];
        steps = 0;
        word  = prog_mem[pc[AddrBits-1:0]];
        while (word[31:24] != 8'hFF) begin
            if (steps == 100) begin
                $display("Program of launch %0d never reaches a stop", n);
                stop_failed();
            end
            // Jump, 16 bit add wraps like a signed offset
            if (word[31:24] == 8'h20) begin
                pc = pc + word[15:0];
            end else begin
                rec.wid  = wid;
                rec.inst = word[31:24];
                rec.dst  = word[23:16];
                rec.op0  = word[15:8];
                rec.op1  = word[7:0];
                rec.req  = operand_flags(word[31:24]);
                rec.pc   = pc;
                rec.mask = mask;
                exp_q.push_back(rec);
                pc = pc + 16'd1;
            end
            steps++;
            word = prog_mem[pc[AddrBits-1:0]];
        end
    endtask

    // Oldest record of the issuing warp, order between warps is free
    task automatic take_issue();
        rec_t want;
        int   idx;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i].wid == issue_warp_id_o)
                idx = i;
        end
        if (idx < 0) begin
            $display("Warp %0d issued at %0t with no record left for it",
                     issue_warp_id_o, $time);
            stop_failed();
        end else begin
            want = exp_q[idx];
            exp_q.delete(idx);
            check_value("opcode", 64'(issue_inst_o), 64'(want.inst));
            check_value("dst", 64'(issue_dst_o), 64'(want.dst));
            check_value("operand 0", 64'(issue_operands_o[0]), 64'(want.op0));
            check_value("operand 1", 64'(issue_operands_o[1]), 64'(want.op1));
            check_value("operand flags", 64'(issue_operands_required_o), 64'(want.req));
            check_value("pc", 64'(issue_pc_o), 64'(want.pc));
            check_value("mask", 64'(issue_act_mask_o), 64'(want.mask));
        end
    endtask

    // Falling edge, random back-pressure, then the transfer due at the next rise
    task automatic tick();
        @(negedge clk_i);
        issue_ready_i = ($urandom % 4) != 0;
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout, warps still busy after %0d cycles", limit);
                stop_failed();
            end
        end
        if (issue_valid_o === 1'b1 && issue_ready_i)
            take_issue();
    endtask

    // One cycle start strobe
    task automatic launch(input int n);
        tick();
        start_i = 1'b1;
        {start_warp_id_i, start_pc_i, start_mask_i} = start_tbl[n];
        tick();
        start_i = 1'b0;
        check_value("active bit", 64'(warps_active_o[start_warp_id_i]), 64'd1);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || warps_active_o != '0)
            tick();
    endtask

    initial begin : main
        void'($urandom(22));
        reset_i         = 1'b1;
        start_i         = 1'b0;
        start_warp_id_i = '0;
        start_pc_i      = '0;
        start_mask_i    = '0;
        imem_we_i       = 1'b0;
        imem_addr_i     = '0;
        imem_wdata_i    = '0;
        issue_ready_i   = 1'b0;
        running         = 1'b0;
        cycles          = 0;

        prog_tbl = '{
            // Warp 0 and 3, IU and LSU mix
            {16'h0010, 32'h0003_0102}, {16'h0011, 32'h0104_0301},
            {16'h0012, 32'h0605_047F}, {16'h0013, 32'h1006_0504},
            {16'h0014, 32'h0807_0603}, {16'h0015, 32'h0408_0705},
            {16'h0016, 32'hFF00_0000},
            // Warp 1, jump forward to 0x31 then back to 0x28
            {16'h0020, 32'h020A_0102}, {16'h0021, 32'h2000_0010},
            {16'h0031, 32'h030B_0A01}, {16'h0032, 32'h2000_FFF6},
            {16'h0028, 32'h070C_0B20},
            // Warp 2
            {16'h0040, 32'h1011_1213}, {16'h0041, 32'h0414_1112},
            {16'h0042, 32'h0515_1402}, {16'h0043, 32'h0016_1514},
            // Warp 5, BR passes through, jump into warp 7 code
            {16'h0050, 32'h0621_0005}, {16'h0051, 32'h2100_2122},
            {16'h0052, 32'h2000_000E}
        };
        start_tbl = '{
            {3'd0, 16'h0010, 32'hFFFF_FFFF},
            {3'd1, 16'h0020, 32'h0000_FFFF},
            {3'd2, 16'h0040, 32'hF0F0_F0F0},
            {3'd5, 16'h0050, 32'h8000_0001},
            {3'd7, 16'h0060, 32'h1234_5678},
            {3'd3, 16'h0010, 32'h0F0F_0F0F}
        };

        // Unused words stop, low half carries the address
        for (int a = 0; a < `BGPU_IMEM_DEPTH; a++)
            prog_mem[a] = {8'hFF, 8'h00, 16'(a)};
        prog_mem[8'h60] = 32'h0531_3233;
        prog_mem[8'h61] = 32'h1034_3130;
        for (int p = 0; p < NumProg; p++)
            prog_mem[prog_tbl[p][AddrBits+31:32]] = prog_tbl[p][31:0];

        repeat (5) tick();
        reset_i = 1'b0;

        // Nothing may issue or run before the first start
        for (int a = 0; a < `BGPU_IMEM_DEPTH; a++) begin
            tick();
            imem_we_i    = 1'b1;
            imem_addr_i  = bgpu_pkg::pc_t'(a);
            imem_wdata_i = prog_mem[a];
            check_value("issue valid before start", 64'(issue_valid_o), 64'd0);
            check_value("active before start", 64'(warps_active_o), 64'd0);
        end
        tick();
        imem_we_i = 1'b0;

        // Budget from the full expectation count
        for (int n = 0; n < NumStarts; n++)
            expect_start(n);
        limit = 50 * exp_q.size() + 200;
        exp_q.delete();
        running = 1'b1;

        // Single warp alone
        expect_start(0);
        launch(0);
        wait_drained();

        // Several warps together
        for (int n = 1; n < NumStarts; n++)
            expect_start(n);
        for (int n = 1; n < NumStarts; n++)
            launch(n);
        wait_drained();

        // Stopped warps stay quiet
        repeat (20) tick();
        check_value("active after stop", 64'(warps_active_o), 64'd0);
        check_value("issue valid after stop", 64'(issue_valid_o), 64'd0);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* bgpu_frontend.f */
+incdir+include
src/bgpu_pkg.sv
src/decode_if.sv
src/fetcher.sv
src/inst_mem.sv
src/decoder.sv
src/dispatch_buffer.sv
src/bgpu_frontend.sv
tb/tb_bgpu_frontend.sv

/* Makefile */
# Verilator build and run of the GPU front end testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_bgpu_frontend
FILELIST  := bgpu_frontend.f
PASS_MSG  := Done: no errors

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
